// File: hw/hatch_pkg.sv
// shared types and constants for the egg game; board dividers assume a 50 MHz clk
`default_nettype none

package hatch_pkg;

    // game states, 3 bits
    typedef enum logic [2:0]
    {
        ST_OFF,
        ST_READY,
        ST_HATCH,
        ST_GROW,
        ST_DONE,
        ST_FAIL
    } hatch_state_t;

    // egg stage 0..16
    typedef logic [4:0] stage_t;
    // elapsed seconds, saturating
    typedef logic [6:0] secs_t;
    // consecutive cold seconds 0..5
    typedef logic [2:0] cold_t;

    // fsm to timer
    typedef struct packed
    {
        logic run;
        logic cold;
        logic clear;
    } hatch_ctrl_t;

    // timer back to fsm and displays
    typedef struct packed
    {
        secs_t  elapsed;
        cold_t  cold;
        stage_t stage;
    } hatch_count_t;

    // thresholds
    localparam stage_t GROW_STAGE = 5'd10;
    localparam stage_t DONE_STAGE = 5'd16;
    localparam cold_t  COLD_LIMIT = 3'd5;
    localparam secs_t  SECS_MAX   = 7'd99;

    // board divider defaults
    localparam int TICK_DIV_BOARD = 50_000_000;
    localparam int SCAN_DIV_BOARD = 50_000;
    localparam int DEBOUNCE_BOARD = 500_000;

    // active low, {a,b,c,d,e,f,g,dp} from msb down
    localparam logic [0:9][7:0] SEG_FONT =
    {
        8'h03, 8'h9F, 8'h25, 8'h0D, 8'h99,
        8'h49, 8'h41, 8'h1F, 8'h01, 8'h09
    };
    localparam logic [7:0] SEG_BLANK = 8'hFF;

endpackage

`default_nettype wire

// File: hw/btn_debounce.sv
// btn is asynchronous and active high; release is taken at once, only the press is filtered
`default_nettype none
`timescale 1ns/1ps

module btn_debounce
    import hatch_pkg::*;
#(
    parameter int DEBOUNCE_CYCLES = DEBOUNCE_BOARD
)
(
    input  wire  clk,
    input  wire  sw7,
    input  wire  btn,
    output logic press
);

    localparam int CW = $clog2(DEBOUNCE_CYCLES + 1);

    logic          btn_meta;
    logic          btn_s;
    logic [CW-1:0] stable_cnt;
    // set once a press has been reported, cleared on release
    logic          pressed;

    // two flop synchroniser
    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            btn_meta <= 1'b0;
            btn_s    <= 1'b0;
        end
        else
        begin
            btn_meta <= btn;
            btn_s    <= btn_meta;
        end
    end

    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            stable_cnt <= '0;
            pressed    <= 1'b0;
            press      <= 1'b0;
        end
        else if (!btn_s)
        begin
            // any low sample restarts the count
            stable_cnt <= '0;
            pressed    <= 1'b0;
            press      <= 1'b0;
        end
        else if (stable_cnt != CW'(DEBOUNCE_CYCLES))
        begin
            stable_cnt <= stable_cnt + 1'b1;
            press      <= 1'b0;
        end
        else
        begin
            // stable long enough, one pulse per hold
            press   <= !pressed;
            pressed <= 1'b1;
        end
    end

    a_press_single: assert property (@(posedge clk) disable iff (!sw7) press |=> !press)
        else $error("press held high for more than one cycle");

endmodule

`default_nettype wire

// File: hw/tick_timer.sv
// TICK_DIV and SCAN_DIV must be at least 2; counters only move while the fsm allows it
`default_nettype none
`timescale 1ns/1ps

module tick_timer
    import hatch_pkg::*;
#(
    parameter int TICK_DIV = TICK_DIV_BOARD,
    parameter int SCAN_DIV = SCAN_DIV_BOARD
)
(
    input  wire          clk,
    input  wire          sw7,
    input  hatch_ctrl_t  ctrl,
    output hatch_count_t cnt,
    output logic         scan
);

    localparam int TW = $clog2(TICK_DIV + 1);
    localparam int SW = $clog2(SCAN_DIV + 1);

    logic [TW-1:0] tick_cnt;
    logic [SW-1:0] scan_cnt;
    logic          tick;
    // toggles each run tick, stage moves on every second one
    logic          half;
    secs_t         elapsed_q;
    cold_t         cold_q;
    stage_t        stage_q;

    assign tick = (tick_cnt == TW'(TICK_DIV - 1));
    assign scan = (scan_cnt == SW'(SCAN_DIV - 1));

    // dividers, phase restarts on clear
    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            tick_cnt <= '0;
            scan_cnt <= '0;
        end
        else
        begin
            tick_cnt <= (ctrl.clear || tick) ? '0 : tick_cnt + 1'b1;
            scan_cnt <= (ctrl.clear || scan) ? '0 : scan_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            elapsed_q <= '0;
            cold_q    <= '0;
            stage_q   <= '0;
            half      <= 1'b0;
        end
        else if (ctrl.clear)
        begin
            elapsed_q <= '0;
            cold_q    <= '0;
            stage_q   <= '0;
            half      <= 1'b0;
        end
        else
        begin
            if (tick && ctrl.run)
            begin
                if (elapsed_q != SECS_MAX)
                    elapsed_q <= elapsed_q + 1'b1;
                half <= !half;
                if (half && stage_q != DONE_STAGE)
                    stage_q <= stage_q + 1'b1;
            end
            // low cold field zeroes at once; with run low it just holds
            if (!ctrl.cold)
                cold_q <= '0;
            else if (tick && ctrl.run && cold_q != COLD_LIMIT)
                cold_q <= cold_q + 1'b1;
        end
    end

    assign cnt = '{elapsed: elapsed_q, cold: cold_q, stage: stage_q};

    a_stage_max: assert property (@(posedge clk) disable iff (!sw7) stage_q <= DONE_STAGE)
        else $error("stage past DONE_STAGE");
    a_cold_max: assert property (@(posedge clk) disable iff (!sw7) cold_q <= COLD_LIMIT)
        else $error("cold count past COLD_LIMIT");

endmodule

`default_nettype wire

// File: hw/hatch_fsm.sv
// heat (sw0) is synchronised here, so the heater acts two clocks late; press must be one pulse
`default_nettype none
`timescale 1ns/1ps

module hatch_fsm
    import hatch_pkg::*;
(
    input  wire          clk,
    input  wire          sw7,
    input  wire          press,
    input  wire          heat,
    input  hatch_count_t cnt,
    output hatch_ctrl_t  ctrl,
    output hatch_state_t state,
    output logic         led0,
    output logic         led2
);

    hatch_state_t state_nx;
    logic         heat_meta;
    logic         heat_s;

    // switch synchroniser
    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            heat_meta <= 1'b0;
            heat_s    <= 1'b0;
        end
        else
        begin
            heat_meta <= heat;
            heat_s    <= heat_meta;
        end
    end

    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
            state <= ST_OFF;
        else
            state <= state_nx;
    end

    always_comb
    begin
        state_nx = state;
        case (state)
            // power up, straight to ready
            ST_OFF:
                state_nx = ST_READY;
            ST_READY:
                if (press)
                    state_nx = ST_HATCH;
            // growth wins over a cold count on the same tick
            ST_HATCH:
                if (cnt.stage >= GROW_STAGE)
                    state_nx = ST_GROW;
                else if (cnt.cold >= COLD_LIMIT)
                    state_nx = ST_FAIL;
            ST_GROW:
                if (cnt.stage == DONE_STAGE)
                    state_nx = ST_DONE;
            ST_DONE, ST_FAIL:
                if (press)
                    state_nx = ST_READY;
            default:
                state_nx = ST_OFF;
        endcase
    end

    // counter control
    // cold stays high in fail so the final count is kept for the display
    assign ctrl = '{
        run:   (state == ST_HATCH) || (state == ST_GROW),
        cold:  ((state == ST_HATCH) && !heat_s) || (state == ST_FAIL),
        clear: (state == ST_READY) && press
    };

    // leds follow the state register
    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            led0 <= 1'b0;
            led2 <= 1'b0;
        end
        else
        begin
            led0 <= (state_nx == ST_DONE);
            led2 <= (state_nx == ST_FAIL);
        end
    end

    // clear only on the way from ready into a new round
    a_clear_start: assert property (@(posedge clk) disable iff (!sw7)
        ctrl.clear |-> (state == ST_READY) ##1 (state == ST_HATCH))
        else $error("clear outside the start of a round");

endmodule

`default_nettype wire

// File: hw/seg_display.sv
// digits are scanned only while powered; elapsed above 99 is not expected on the display
`default_nettype none
`timescale 1ns/1ps

module seg_display
    import hatch_pkg::*;
(
    input  wire          clk,
    input  wire          sw7,
    input  wire          scan,
    input  hatch_state_t state,
    input  hatch_count_t cnt,
    output logic [7:0]   seg,
    output logic [7:0]   dig
);

    logic [2:0] dig_idx;
    logic [3:0] tens;
    logic [3:0] units;
    logic       show;

    // next digit on each scan pulse
    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
            dig_idx <= '0;
        else if (scan)
            dig_idx <= dig_idx + 1'b1;
    end

    // bcd split of elapsed, one clock behind
    always_ff @(posedge clk)
    begin
        tens  <= 4'(cnt.elapsed / 7'd10);
        units <= 4'(cnt.elapsed % 7'd10);
    end

    // counts only visible once a round has started
    assign show = (state != ST_OFF) && (state != ST_READY);

    always_comb
    begin
        dig = 8'hFF;
        seg = SEG_BLANK;
        // off is fully dark, ready still scans but with blank segments
        if (state != ST_OFF)
            dig = ~(8'b1 << dig_idx);
        if (show)
        begin
            case (dig_idx)
                3'd0:
                    seg = SEG_FONT[units];
                3'd1:
                    seg = SEG_FONT[tens];
                // leftmost digit, cold seconds
                3'd7:
                    seg = SEG_FONT[cnt.cold];
                default:
                    seg = SEG_BLANK;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/matrix_display.sv
// one static frame per state; crack pixels follow stage only while hatching
`default_nettype none
`timescale 1ns/1ps

module matrix_display
    import hatch_pkg::*;
(
    input  wire          clk,
    input  wire          sw7,
    input  wire          scan,
    input  hatch_state_t state,
    input  stage_t       stage,
    output logic [7:0]   row,
    output logic [7:0]   colg,
    output logic [7:0]   colr
);

    logic [2:0] row_idx;
    logic [7:0] egg_g;
    // number of cracks, stage/2
    logic [3:0] crack_n;
    logic [7:0] crack_r;

    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
            row_idx <= '0;
        else if (scan)
            row_idx <= row_idx + 1'b1;
    end

    assign crack_n = stage[4:1];
    assign row     = (state == ST_OFF) ? 8'hFF : ~(8'b1 << row_idx);

    // egg outline and crack pattern for the current row
    always_comb
    begin
        case (row_idx)
            3'd0, 3'd7:
                egg_g = 8'h3C;
            3'd1, 3'd6:
                egg_g = 8'h42;
            default:
                egg_g = 8'h81;
        endcase
        case (row_idx)
            3'd2:
                crack_r = (crack_n >= 4'd1) ? 8'h10 : 8'h00;
            3'd3:
                crack_r = (crack_n >= 4'd2) ? 8'h08 : 8'h00;
            3'd4:
                crack_r = (crack_n >= 4'd3) ? 8'h10 : 8'h00;
            3'd5:
                crack_r = (crack_n >= 4'd4) ? 8'h08 : 8'h00;
            default:
                crack_r = 8'h00;
        endcase
    end

    always_comb
    begin
        colg = 8'h00;
        colr = 8'h00;
        case (state)
            ST_READY:
                colg = egg_g;
            ST_HATCH:
            begin
                colg = egg_g;
                colr = crack_r;
            end
            // head out, bottom shell kept
            ST_GROW:
                colg = (row_idx >= 3'd4) ? egg_g :
                       (row_idx == 3'd0) ? 8'h00 :
                       (row_idx == 3'd1) ? 8'h18 : 8'h3C;
            ST_DONE:
                case (row_idx)
                    3'd0:    colg = 8'h18;
                    3'd1:    colg = 8'h3C;
                    3'd3:    colg = 8'h3C;
                    3'd5:    colg = 8'hFF;
                    3'd7:    colg = 8'h24;
                    default: colg = 8'h7E;
                endcase
            // diagonal cross
            ST_FAIL:
                colr = (8'b1 << row_idx) | (8'h80 >> row_idx);
            default:
            begin
                colg = 8'h00;
                colr = 8'h00;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/eggs_hatch_top.sv
// board top; sw7 is power and active-low reset, divider parameters default to a 50 MHz board
`default_nettype none
`timescale 1ns/1ps

module eggs_hatch_top
    import hatch_pkg::*;
#(
    parameter int TICK_DIV        = TICK_DIV_BOARD,
    parameter int SCAN_DIV        = SCAN_DIV_BOARD,
    parameter int DEBOUNCE_CYCLES = DEBOUNCE_BOARD
)
(
    input  wire        clk,
    input  wire        sw7,
    input  wire        btn0,
    input  wire        sw0,
    output logic       led0,
    output logic       led2,
    output logic [7:0] row,
    output logic [7:0] colg,
    output logic [7:0] colr,
    output logic [7:0] seg,
    output logic [7:0] dig
);

    logic         press;
    logic         scan;
    hatch_ctrl_t  ctrl;
    hatch_count_t cnt;
    hatch_state_t state;

    // start / return button
    btn_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) db0
    (
        .clk(clk), .sw7(sw7), .btn(btn0), .press(press)
    );

    // second tick, scan pulse and round counters
    tick_timer #(.TICK_DIV(TICK_DIV), .SCAN_DIV(SCAN_DIV)) tmr0
    (
        .clk(clk), .sw7(sw7), .ctrl(ctrl), .cnt(cnt), .scan(scan)
    );

    // sw0 is the heater
    hatch_fsm fsm0
    (
        .clk(clk), .sw7(sw7), .press(press), .heat(sw0), .cnt(cnt),
        .ctrl(ctrl), .state(state), .led0(led0), .led2(led2)
    );

    seg_display seg0
    (
        .clk(clk), .sw7(sw7), .scan(scan), .state(state), .cnt(cnt),
        .seg(seg), .dig(dig)
    );

    matrix_display mat0
    (
        .clk(clk), .sw7(sw7), .scan(scan), .state(state), .stage(cnt.stage),
        .row(row), .colg(colg), .colr(colr)
    );

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
// free-running clock of PERIOD_NS ns; rst_n stays low for RESET_CYCLES rising edges from time 0
`default_nettype none
`timescale 1ns/1ps

module tb_clock
#(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 10
)
(
    output logic clk,
    output logic rst_n
);

    // half period per toggle
    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // power-up reset, released on a rising edge
    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: verif/tb_eggs_hatch.sv
// small dividers for simulation; round timing is estimated from the press edge with a window
`default_nettype none
`timescale 1ns/1ps

module tb_eggs_hatch;

    localparam int TICK_DIV    = 40;
    // btn0 edge to first cycle of the round, sync plus debounce plus fsm
    localparam int START_LAT   = 8;
    // slack on round lengths, in cycles
    localparam int WINDOW      = 20;
    localparam int DONE_TICKS  = 32;
    // two full rounds, three short ones, plus button traffic
    localparam int TEST_CYC    = (2 * DONE_TICKS + 6 + 10 + 12) * TICK_DIV + 300;
    localparam int TIMEOUT_CYC = 3 * TEST_CYC;

    logic       clk;
    logic       rst_n;
    logic       power_on;
    wire        sw7;
    logic       btn0;
    logic       sw0;
    logic       led0;
    logic       led2;
    logic [7:0] row;
    logic [7:0] colg;
    logic [7:0] colr;
    logic [7:0] seg;
    logic [7:0] dig;

    int cyc;
    int n_checks;
    int n_errors;

    // power switch is the reset too
    assign sw7 = rst_n & power_on;

    tb_clock #(.PERIOD_NS(4), .RESET_CYCLES(10)) clk0
    (
        .clk(clk), .rst_n(rst_n)
    );

    eggs_hatch_top #(.TICK_DIV(TICK_DIV), .SCAN_DIV(2), .DEBOUNCE_CYCLES(4)) dut0
    (
        .clk(clk), .sw7(sw7), .btn0(btn0), .sw0(sw0), .led0(led0), .led2(led2),
        .row(row), .colg(colg), .colr(colr), .seg(seg), .dig(dig)
    );

    // cycle count and hang guard
    always @(posedge clk)
    begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYC)
        begin
            $display("run stopped after %0d cycles before the tests were done", cyc);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // active low, bit 7 is segment a down to g, bit 0 is dp
    function automatic logic [7:0] seg_code(input int d);
        case (d)
            0:       seg_code = 8'h03;   // a b c d e f
            1:       seg_code = 8'h9F;   // b c
            2:       seg_code = 8'h25;   // a b d e g
            3:       seg_code = 8'h0D;   // a b c d g
            4:       seg_code = 8'h99;   // b c f g
            5:       seg_code = 8'h49;   // a c d f g
            6:       seg_code = 8'h41;   // a c d e f g
            7:       seg_code = 8'h1F;   // a b c
            8:       seg_code = 8'h01;
            9:       seg_code = 8'h09;   // all but e
            default: seg_code = 8'hFF;
        endcase
    endfunction

    task automatic press_button();
        @(posedge clk);
        btn0 <= 1'b1;
        repeat (10) @(posedge clk);
        btn0 <= 1'b0;
        repeat (10) @(posedge clk);
    endtask

    task automatic set_heater(input logic on);
        @(posedge clk);
        sw0 <= on;
    endtask

    // t0 is the cycle count just before btn0 goes high
    task automatic start_round(output int t0);
        @(negedge clk);
        t0 = cyc;
        press_button();
    endtask

    task automatic at_cycle(input int target);
        while (cyc < target)
            @(negedge clk);
        @(posedge clk);
    endtask

    // waits for digit idx to be scanned, samples seg mid-cycle
    task automatic read_digit(input logic [2:0] idx, output logic [7:0] seg_val);
        int n;
        n = 0;
        @(negedge clk);
        while (dig !== ~(8'b1 << idx) && n < 64)
        begin
            @(negedge clk);
            n++;
        end
        if (n >= 64)
        begin
            n_errors++;
            $display("digit %0d was never selected by the scan", idx);
        end
        seg_val = seg;
    endtask

    task automatic check_digits(input int tens, input int units, input int cold);
        logic [7:0] s;
        read_digit(3'd0, s);
        check_value("seg digit 0", s, seg_code(units));
        read_digit(3'd1, s);
        check_value("seg digit 1", s, seg_code(tens));
        read_digit(3'd7, s);
        check_value("seg digit 7", s, seg_code(cold));
        // unused digit stays dark
        read_digit(3'd4, s);
        check_value("seg digit 4", s, 8'hFF);
    endtask

    task automatic check_blank();
        logic [7:0] s;
        for (int i = 0; i < 8; i++)
        begin
            read_digit(3'(i), s);
            check_value($sformatf("seg digit %0d", i), s, 8'hFF);
        end
    endtask

    // led rise must land within WINDOW cycles after ticks seconds
    task automatic wait_led(input logic use_led2, input int ticks, input int t0);
        int   limit;
        int   diff;
        logic seen;
        limit = ticks * TICK_DIV + 100;
        seen  = 1'b0;
        while (!seen && (cyc - t0) < limit)
        begin
            @(negedge clk);
            seen = use_led2 ? led2 : led0;
        end
        diff = cyc - t0;
        n_checks++;
        if (!seen)
        begin
            n_errors++;
            $display("led%0d did not rise within %0d cycles", use_led2 ? 2 : 0, limit);
        end
        else if (diff < ticks * TICK_DIV || diff > ticks * TICK_DIV + WINDOW)
        begin
            n_errors++;
            $display("led%0d rose after %0d cycles, outside %0d ticks plus %0d",
                     use_led2 ? 2 : 0, diff, ticks, WINDOW);
        end
    endtask

    // press from done or fail, back to a blank ready
    task automatic return_ready();
        press_button();
        @(negedge clk);
        check_value("led0", 8'(led0), 8'd0);
        check_value("led2", 8'(led2), 8'd0);
        check_blank();
    endtask

    task automatic test_reset_idle();
        // still inside the power-up reset
        repeat (3)
        begin
            @(negedge clk);
            check_value("led0", 8'(led0), 8'd0);
            check_value("led2", 8'(led2), 8'd0);
            check_value("dig", dig, 8'hFF);
            check_value("row", row, 8'hFF);
            check_value("colg", colg, 8'h00);
            check_value("colr", colr, 8'h00);
        end
        while (sw7 !== 1'b1)
            @(negedge clk);
        repeat (4) @(negedge clk);
        check_value("led0", 8'(led0), 8'd0);
        check_value("led2", 8'(led2), 8'd0);
        check_blank();
    endtask

    task automatic test_heater_on();
        int t0;
        set_heater(1'b1);
        repeat (4) @(posedge clk);
        start_round(t0);
        wait_led(1'b0, DONE_TICKS, t0);
        check_digits(3, 2, 0);
        check_value("led2", 8'(led2), 8'd0);
    endtask

    task automatic test_heater_off();
        int         t0;
        logic [7:0] acc;
        set_heater(1'b0);
        repeat (4) @(posedge clk);
        start_round(t0);
        wait_led(1'b1, 5, t0);
        check_digits(0, 5, 5);
        check_value("led0", 8'(led0), 8'd0);
        // one full row sweep
        acc = 8'h00;
        repeat (16)
        begin
            @(negedge clk);
            acc = acc | colr;
        end
        n_checks++;
        if (acc == 8'h00)
        begin
            n_errors++;
            $display("colr stayed zero over a full row scan in the failed state");
        end
    endtask

    // off 3 s, on 1 s, then off again
    task automatic test_heater_gap();
        int t0;
        set_heater(1'b0);
        repeat (4) @(posedge clk);
        start_round(t0);
        at_cycle(t0 + START_LAT + 3 * TICK_DIV + TICK_DIV / 2);
        sw0 <= 1'b1;
        at_cycle(t0 + START_LAT + 4 * TICK_DIV + TICK_DIV / 2);
        sw0 <= 1'b0;
        wait_led(1'b1, 9, t0);
        check_digits(0, 9, 5);
    endtask

    // cold after stage 10 no longer matters
    task automatic test_late_cold();
        int t0;
        set_heater(1'b1);
        repeat (4) @(posedge clk);
        start_round(t0);
        at_cycle(t0 + START_LAT + 20 * TICK_DIV + TICK_DIV / 2);
        sw0 <= 1'b0;
        wait_led(1'b0, DONE_TICKS, t0);
        check_digits(3, 2, 0);
        check_value("led2", 8'(led2), 8'd0);
    endtask

    task automatic test_power_loss();
        int t0;
        set_heater(1'b1);
        repeat (4) @(posedge clk);
        start_round(t0);
        at_cycle(t0 + START_LAT + 10 * TICK_DIV);
        power_on <= 1'b0;
        @(negedge clk);
        check_value("led0", 8'(led0), 8'd0);
        check_value("led2", 8'(led2), 8'd0);
        check_value("dig", dig, 8'hFF);
        check_value("row", row, 8'hFF);
        check_value("colg", colg, 8'h00);
        check_value("colr", colr, 8'h00);
        repeat (5) @(posedge clk);
        power_on <= 1'b1;
        // back up into ready
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("led0", 8'(led0), 8'd0);
        check_blank();
    endtask

    initial
    begin
        btn0     = 1'b0;
        sw0      = 1'b0;
        power_on = 1'b1;
        cyc      = 0;
        n_checks = 0;
        n_errors = 0;

        test_reset_idle();
        test_heater_on();
        return_ready();
        test_heater_off();
        return_ready();
        test_heater_gap();
        return_ready();
        test_late_cold();
        return_ready();
        test_power_loss();

        $display("tb_eggs_hatch: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
hw/hatch_pkg.sv
hw/btn_debounce.sv
hw/tick_timer.sv
hw/hatch_fsm.sv
hw/seg_display.sv
hw/matrix_display.sv
hw/eggs_hatch_top.sv
verif/tb_clock.sv
verif/tb_eggs_hatch.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -j 0 --top-module tb_eggs_hatch -f sources.f -Mdir obj_dir
	./obj_dir/Vtb_eggs_hatch | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
